// ==== Makefile ====
# Verilator simulation of the dirty-bit store

VERILATOR ?= verilator
TOP       ?= dcache_dirty_tb
FILELIST  ?= dcache_dirty.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Pass only if the testbench printed its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/dcache_dirty_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

// Protocol assertions for the dirty-bit store, bound into dcache_dirty
module dcache_dirty_checker (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 busy,
  input  wire logic                 sweep_clear,
  input  wire logic                 clear_valid,
  input  dcache_dirty_pkg::ram_wr_t wr0,
  input  dcache_dirty_pkg::ram_wr_t wr1
);

  // Sweep takes exactly eight cycles once reset is released
  a_sweep_length: assert property (
    @(posedge clk) disable iff (rst) $fell(rst) |-> ##8 $fell(busy)
  ) else $error("busy did not fall eight cycles after reset release");

  // and it cannot end early either
  a_sweep_not_early: assert property (
    @(posedge clk) disable iff (rst) $fell(busy) |-> $past(rst, 9)
  ) else $error("busy fell before the sweep could have covered all rows");

  // While busy, port 0 only carries sweep clears
  a_no_external_busy: assert property (
    @(posedge clk) disable iff (rst)
      busy |-> (!wr0.wen || (sweep_clear && (&wr0.bit_en) && !(|wr0.data)))
  ) else $error("external request reached write port 0 during the sweep");

  // Single-line writes touch one bit
  a_port0_onehot: assert property (
    @(posedge clk) disable iff (rst)
      (wr0.wen && !sweep_clear && !clear_valid) |-> $onehot(wr0.bit_en)
  ) else $error("port 0 store or fill bit enable is not one-hot");

  a_port1_onehot: assert property (
    @(posedge clk) disable iff (rst) wr1.wen |-> $onehot(wr1.bit_en)
  ) else $error("port 1 store bit enable is not one-hot");

endmodule

`default_nettype wire

// ==== bench/dcache_dirty_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_dirty_cfg.svh"

module dcache_dirty_tb;

  localparam int CLK_PERIOD  = 20;
  localparam int N_LINES     = `DD_ROWS * `DD_COLS;
  localparam int N_STORE     = 200;
  localparam int N_FILL      = 200;
  localparam int N_CLEAR     = 3;
  localparam int N_HOLD      = 40;
  localparam int SWEEP_LIMIT = 20;
  localparam int READ_PASS   = N_LINES + 1;
  // All phases of the run with some slack
  localparam int TOTAL_CYCLES = 2 * (4 + SWEEP_LIMIT) + N_STORE + N_FILL + N_HOLD + N_CLEAR
                              + (N_CLEAR + 4) * READ_PASS + 10;
  localparam int WATCHDOG_NS = 2 * TOTAL_CYCLES * CLK_PERIOD;

  logic                         clk = 1'b0;
  logic                         rst;
  dcache_dirty_pkg::store_req_t store0;
  dcache_dirty_pkg::store_req_t store1;
  dcache_dirty_pkg::fill_req_t  fill;
  logic                         clear_valid;
  logic [`DD_ROW_W-1:0]         clear_row;
  logic                         read_en;
  dcache_dirty_pkg::line_u      read_line;
  logic                         read_dirty;
  logic                         busy;

  // Reference state
  logic [N_LINES-1:0]    model_bits = '0;
  logic                  model_busy = 1'b1;
  logic [`DD_ROW_W-1:0]  model_row  = '0;
  logic [`DD_LINE_W-1:0] model_rd   = '0;
  logic                  model_live = 1'b0;

  logic [31:0] lfsr_state  = 32'haec84a92;
  int          error_count = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  dcache_dirty DUT (
    .clk         (clk),
    .rst         (rst),
    .store0      (store0),
    .store1      (store1),
    .fill        (fill),
    .clear_valid (clear_valid),
    .clear_row   (clear_row),
    .read_en     (read_en),
    .read_line   (read_line),
    .read_dirty  (read_dirty),
    .busy        (busy)
  );

  bind dcache_dirty dcache_dirty_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .busy        (busy),
    .sweep_clear (sweep_clear),
    .clear_valid (clear_valid),
    .wr0         (wr0),
    .wr1         (wr1)
  );

  // Galois form, right shift, taps x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [N_LINES-1:0] zero_row(input logic [N_LINES-1:0] bits,
                                                  input logic [`DD_ROW_W-1:0] row);
    logic [N_LINES-1:0] res;
    res = bits;
    for (int k = 0; k < `DD_COLS; k++) begin
      res[{row, 3'(k)}] = 1'b0;
    end
    return res;
  endfunction

  // Next array contents for one edge: sweep, clear, fill, store0 on port 0, then store1
  function automatic logic [N_LINES-1:0] model_step(
    input logic [N_LINES-1:0]         cur,
    input logic                       sw_busy,
    input logic [`DD_ROW_W-1:0]       sw_row,
    input dcache_dirty_pkg::store_req_t s0,
    input dcache_dirty_pkg::store_req_t s1,
    input dcache_dirty_pkg::fill_req_t  f,
    input logic                       clr,
    input logic [`DD_ROW_W-1:0]       clr_row
  );
    logic [N_LINES-1:0] nxt;
    nxt = cur;
    if (sw_busy) begin
      nxt = zero_row(nxt, sw_row);
    end else if (clr) begin
      nxt = zero_row(nxt, clr_row);
    end else if (f.valid) begin
      nxt[f.line.idx] = f.dirty;
    end else if (s0.valid) begin
      nxt[s0.line.idx] = 1'b1;
    end
    // Port 1 lands last and wins a shared bit
    if (s1.valid) begin
      nxt[s1.line.idx] = 1'b1;
    end
    return nxt;
  endfunction

  always @(posedge clk) begin
    model_bits <= model_step(model_bits, model_busy, model_row, store0, store1, fill,
                             clear_valid, clear_row);
    model_live <= 1'b1;
    if (rst) begin
      model_busy <= 1'b1;
      model_row  <= '0;
      model_rd   <= '0;
    end else begin
      // One row per cycle, busy ends after the last row
      if (model_busy) begin
        model_row <= model_row + 1'b1;
        if (model_row == 3'(`DD_ROWS - 1)) begin
          model_busy <= 1'b0;
        end
      end
      if (read_en) begin
        model_rd <= read_line.idx;
      end
    end
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    error_count++;
    abort_run();
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, got, exp);
      error_count++;
      abort_run();
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (model_live) begin
      check("busy", 32'(busy), 32'(model_busy));
      // Array contents only defined once the sweep is over
      if (!model_busy) begin
        check("read_dirty", 32'(read_dirty), 32'(model_bits[model_rd]));
      end
    end
  end

  task automatic clear_inputs();
    store0      <= '0;
    store1      <= '0;
    fill        <= '0;
    clear_valid <= 1'b0;
    clear_row   <= '0;
    read_en     <= 1'b0;
    read_line   <= '0;
  endtask

  task automatic drive_random_stores();
    dcache_dirty_pkg::line_u ln;
    ln.idx = 6'(rand_bits(6));
    store0.valid <= 1'(rand_bits(1));
    store0.line  <= ln;
    store1.valid <= 1'(rand_bits(1));
    // Same line on both ports about a quarter of the time
    if (2'(rand_bits(2)) == 2'd0) begin
      store1.line <= ln;
    end else begin
      store1.line.idx <= 6'(rand_bits(6));
    end
  endtask

  task automatic release_reset(input logic with_stores);
    @(posedge clk);
    clear_inputs();
    rst <= 1'b0;
    if (with_stores) begin
      drive_random_stores();
    end
  endtask

  task automatic wait_sweep(input logic with_stores, output int cycles);
    cycles = 0;
    do begin
      @(posedge clk);
      clear_inputs();
      if (with_stores) begin
        drive_random_stores();
      end
      cycles++;
      @(negedge clk);
    end while (busy && cycles < SWEEP_LIMIT);
    if (busy) begin
      report_error("busy still high long after reset was released");
    end
  endtask

  task automatic read_all_lines();
    for (int i = 0; i < N_LINES; i++) begin
      @(posedge clk);
      clear_inputs();
      read_en        <= 1'b1;
      read_line.idx  <= 6'(i);
    end
    @(posedge clk);
    clear_inputs();
  endtask

  initial begin
    dcache_dirty_pkg::line_u ln;
    int                      n;
    rst <= 1'b1;
    clear_inputs();

    // Reset, sweep length, all lines clean
    repeat (2) @(posedge clk);
    release_reset(1'b0);
    wait_sweep(1'b0, n);
    check("sweep_cycles", 32'(n), 32'd8);
    read_all_lines();

    // Random traffic on both store ports
    for (int i = 0; i < N_STORE; i++) begin
      @(posedge clk);
      clear_inputs();
      drive_random_stores();
    end
    read_all_lines();

    // Fills racing stores on the same line
    for (int i = 0; i < N_FILL; i++) begin
      @(posedge clk);
      clear_inputs();
      ln.idx = 6'(rand_bits(6));
      fill.valid   <= (2'(rand_bits(2)) != 2'd0);
      fill.dirty   <= 1'(rand_bits(1));
      fill.line    <= ln;
      store0.valid <= 1'(rand_bits(1));
      store0.line  <= ln;
      store1.valid <= 1'(rand_bits(1));
      store1.line.idx <= (1'(rand_bits(1))) ? ln.idx : 6'(rand_bits(6));
    end
    read_all_lines();

    // Row clears, store0 in the same cycle is dropped
    for (int i = 0; i < N_CLEAR; i++) begin
      @(posedge clk);
      clear_inputs();
      clear_valid     <= 1'b1;
      clear_row       <= 3'(rand_bits(3));
      store0.valid    <= 1'b1;
      store0.line.idx <= 6'(rand_bits(6));
      read_all_lines();
    end

    // Read held on one line while it is written
    ln.idx = 6'(rand_bits(6));
    @(posedge clk);
    clear_inputs();
    read_en   <= 1'b1;
    read_line <= ln;
    for (int i = 0; i < N_HOLD; i++) begin
      @(posedge clk);
      clear_inputs();
      case (2'(rand_bits(2)))
        2'd0: begin
          store0.valid <= 1'b1;
          store0.line  <= ln;
        end
        2'd1: begin
          store1.valid <= 1'b1;
          store1.line  <= ln;
        end
        2'd2: begin
          fill.valid <= 1'b1;
          fill.dirty <= 1'(rand_bits(1));
          fill.line  <= ln;
        end
        default: begin
          clear_valid <= 1'b1;
          clear_row   <= ln.rc.row;
        end
      endcase
    end

    // Second reset with stores running through it
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      clear_inputs();
      rst <= 1'b1;
      drive_random_stores();
    end
    release_reset(1'b1);
    wait_sweep(1'b1, n);
    check("sweep_cycles", 32'(n), 32'd8);
    read_all_lines();

    @(posedge clk);
    clear_inputs();
    @(negedge clk);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    report_error("watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire

// ==== dcache_dirty.f ====
+incdir+verilog
verilog/dcache_dirty_pkg.sv
verilog/dcache_dirty_ram.sv
verilog/dcache_dirty_sweep.sv
verilog/dcache_dirty_ports.sv
verilog/dcache_dirty.sv
bench/dcache_dirty_checker.sv
bench/dcache_dirty_tb.sv

// ==== verilog/dcache_dirty.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_dirty_cfg.svh"

// Dirty-bit store of a write-back data cache, 64 lines
module dcache_dirty (
  input  wire logic                      clk,
  input  wire logic                      rst,
  // Store ports
  input  dcache_dirty_pkg::store_req_t   store0,
  input  dcache_dirty_pkg::store_req_t   store1,
  // Line fill
  input  dcache_dirty_pkg::fill_req_t    fill,
  // Whole-row clear
  input  wire logic                      clear_valid,
  input  wire logic [`DD_ROW_W-1:0]      clear_row,
  // Read port
  input  wire logic                      read_en,
  input  dcache_dirty_pkg::line_u        read_line,
  output logic                           read_dirty,
  // High while the reset sweep runs
  output logic                           busy
);

  logic                      sweep_clear;
  logic [`DD_ROW_W-1:0]      sweep_row;

  dcache_dirty_pkg::ram_wr_t wr0;
  dcache_dirty_pkg::ram_wr_t wr1;

  logic                      rd_en;
  logic [`DD_ROW_W-1:0]      rd_row;
  logic [`DD_COLS-1:0]       rd_data;

  dcache_dirty_sweep u_sweep (
    .clk         (clk),
    .rst         (rst),
    .sweep_clear (sweep_clear),
    .sweep_row   (sweep_row),
    .busy        (busy)
  );

  dcache_dirty_ports u_ports (
    .clk         (clk),
    .rst         (rst),
    .busy        (busy),
    .sweep_clear (sweep_clear),
    .sweep_row   (sweep_row),
    .store0      (store0),
    .store1      (store1),
    .fill        (fill),
    .clear_valid (clear_valid),
    .clear_row   (clear_row),
    .read_en     (read_en),
    .read_line   (read_line),
    .wr0         (wr0),
    .wr1         (wr1),
    .rd_en       (rd_en),
    .rd_row      (rd_row),
    .rd_data     (rd_data),
    .read_dirty  (read_dirty)
  );

  dcache_dirty_ram u_ram (
    .clk     (clk),
    .rst     (rst),
    .wr0     (wr0),
    .wr1     (wr1),
    .rd_en   (rd_en),
    .rd_row  (rd_row),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// ==== verilog/dcache_dirty_cfg.svh ====
`ifndef DCACHE_DIRTY_CFG_SVH
`define DCACHE_DIRTY_CFG_SVH

// Geometry of the dirty-bit array
// 64 lines are kept as 8 rows of 8 bits

// Number of rows in the array
`define DD_ROWS 8

// Bits per row, one per line
`define DD_COLS 8

// Index widths
`define DD_ROW_W 3
`define DD_COL_W 3

// Flat line index, row in the upper bits
`define DD_LINE_W 6

`endif

// ==== verilog/dcache_dirty_pkg.sv ====
`default_nettype none

`include "dcache_dirty_cfg.svh"

package dcache_dirty_pkg;

  // Line number split into array coordinates
  typedef struct packed {
    logic [`DD_ROW_W-1:0] row;
    logic [`DD_COL_W-1:0] col;
  } line_rc_t;

  // Same line number, seen flat or as row/column
  typedef union packed {
    logic [`DD_LINE_W-1:0] idx;
    line_rc_t              rc;
  } line_u;

  // One store port
  typedef struct packed {
    logic  valid;
    line_u line;
  } store_req_t;

  // Fill of a new line, dirty if the fill already carries a store
  typedef struct packed {
    logic  valid;
    logic  dirty;
    line_u line;
  } fill_req_t;

  // One bit-enabled write port of the array
  typedef struct packed {
    logic                 wen;
    logic [`DD_ROW_W-1:0] row;
    logic [`DD_COLS-1:0]  bit_en;
    logic [`DD_COLS-1:0]  data;
  } ram_wr_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_dirty_ports.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_dirty_cfg.svh"

// Request decode for the two array write ports and the read bit select
module dcache_dirty_ports (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      busy,
  input  wire logic                      sweep_clear,
  input  wire logic [`DD_ROW_W-1:0]      sweep_row,
  input  dcache_dirty_pkg::store_req_t   store0,
  input  dcache_dirty_pkg::store_req_t   store1,
  input  dcache_dirty_pkg::fill_req_t    fill,
  input  wire logic                      clear_valid,
  input  wire logic [`DD_ROW_W-1:0]      clear_row,
  input  wire logic                      read_en,
  input  dcache_dirty_pkg::line_u        read_line,
  output dcache_dirty_pkg::ram_wr_t      wr0,
  output dcache_dirty_pkg::ram_wr_t      wr1,
  output logic                           rd_en,
  output logic      [`DD_ROW_W-1:0]      rd_row,
  input  wire logic [`DD_COLS-1:0]       rd_data,
  output logic                           read_dirty
);

  // Latched column of the line being read
  logic [`DD_COL_W-1:0] rd_col_q;

  // External port 0 traffic is only accepted once the sweep is over
  logic ext_ok;

  // Column to one-hot bit enable
  function automatic logic [`DD_COLS-1:0] col_onehot(input logic [`DD_COL_W-1:0] col);
    logic [`DD_COLS-1:0] oh;
    oh = '0;
    oh[col] = 1'b1;
    return oh;
  endfunction

  assign ext_ok = ~busy;

  // Port 0 in priority order: sweep, clear, fill, store0
  always_comb begin
    wr0 = '0;
    if (sweep_clear) begin
      wr0.wen    = 1'b1;
      wr0.row    = sweep_row;
      wr0.bit_en = '1;
      wr0.data   = '0;
    end else if (ext_ok) begin
      if (clear_valid) begin
        wr0.wen    = 1'b1;
        wr0.row    = clear_row;
        wr0.bit_en = '1;
        wr0.data   = '0;
      end else if (fill.valid) begin
        wr0.wen    = 1'b1;
        wr0.row    = fill.line.rc.row;
        wr0.bit_en = col_onehot(fill.line.rc.col);
        wr0.data   = {`DD_COLS{fill.dirty}};
      end else if (store0.valid) begin
        wr0.wen    = 1'b1;
        wr0.row    = store0.line.rc.row;
        wr0.bit_en = col_onehot(store0.line.rc.col);
        wr0.data   = '1;
      end
    end
  end

  // Port 1 only marks lines dirty, never blocked
  always_comb begin
    wr1        = '0;
    wr1.wen    = store1.valid;
    wr1.row    = store1.line.rc.row;
    wr1.bit_en = col_onehot(store1.line.rc.col);
    wr1.data   = '1;
  end

  // Row goes to the array, column is kept here
  assign rd_en  = read_en;
  assign rd_row = read_line.rc.row;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_col_q <= '0;
    end else if (read_en) begin
      rd_col_q <= read_line.rc.col;
    end
  end

  // Pick the latched line out of the row
  assign read_dirty = rd_data[rd_col_q];

endmodule

`default_nettype wire

// ==== verilog/dcache_dirty_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_dirty_cfg.svh"

// Dirty-bit array with two bit-enabled write ports and one read port
module dcache_dirty_ram (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  dcache_dirty_pkg::ram_wr_t    wr0,
  input  dcache_dirty_pkg::ram_wr_t    wr1,
  input  wire logic                    rd_en,
  input  wire logic [`DD_ROW_W-1:0]    rd_row,
  output logic      [`DD_COLS-1:0]     rd_data
);

  // One dirty bit per line
  logic [`DD_COLS-1:0] mem [`DD_ROWS];

  // Registered read row
  logic [`DD_ROW_W-1:0] rd_row_q;

  // Bit writes
  // Port 1 comes last in the block so it wins on a shared bit
  always_ff @(posedge clk) begin
    if (wr0.wen) begin
      for (int k = 0; k < `DD_COLS; k++) begin
        if (wr0.bit_en[k]) begin
          mem[wr0.row][k] <= wr0.data[k];
        end
      end
    end
    if (wr1.wen) begin
      for (int k = 0; k < `DD_COLS; k++) begin
        if (wr1.bit_en[k]) begin
          mem[wr1.row][k] <= wr1.data[k];
        end
      end
    end
  end

  // Read address register
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_row_q <= '0;
    end else if (rd_en) begin
      rd_row_q <= rd_row;
    end
  end

  // Row contents follow later writes to the latched row
  assign rd_data = mem[rd_row_q];

endmodule

`default_nettype wire

// ==== verilog/dcache_dirty_sweep.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_dirty_cfg.svh"

// Clears every row of the array after reset
module dcache_dirty_sweep (
  input  wire logic                 clk,
  input  wire logic                 rst,
  output logic                      sweep_clear,
  output logic [`DD_ROW_W-1:0]      sweep_row,
  output logic                      busy
);

  localparam logic [`DD_ROW_W-1:0] LAST_ROW = `DD_ROW_W'(`DD_ROWS - 1);

  logic [`DD_ROW_W-1:0] row_q;
  logic                 busy_q;

  // Row counter and busy flag
  // Both held at their start values through reset
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b1;
      row_q  <= '0;
    end else if (busy_q) begin
      row_q <= row_q + 1'b1;
      // Done once the last row has been cleared
      if (row_q == LAST_ROW) begin
        busy_q <= 1'b0;
      end
    end
  end

  // One clear per cycle while the sweep runs
  assign sweep_clear = busy_q;
  assign sweep_row   = row_q;
  assign busy        = busy_q;

endmodule

`default_nettype wire
